/* Bender.yml */
package:
  name: clock_display

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/clock_display_pkg.sv
      - src/wb_mode_regs.sv
      - src/time_editor.sv
      - src/digit_composer.sv
      - src/clock_display_top.sv
  - target: test
    include_dirs:
      - src
      - tb
    files:
      - tb/clock_display_tb.sv

/* flist.f */
+incdir+src
+incdir+tb
src/clock_display_pkg.sv
src/wb_mode_regs.sv
src/time_editor.sv
src/digit_composer.sv
src/clock_display_top.sv
tb/clock_display_tb.sv

/* src/clock_display_macros.svh */
`ifndef CLOCK_DISPLAY_MACROS_SVH
`define CLOCK_DISPLAY_MACROS_SVH

// display geometry
`define CD_DIGITS 8
`define CD_DIGIT_W 4
`define CD_LED_W 6  // blink, dot, digit

// digit code shown between the time fields
`define CD_SEP_CODE 4'd10

// wishbone register map
`define CD_WB_DATA_W 32
`define CD_WB_ADDR_W 2
`define CD_REG_MODE 2'd0
`define CD_REG_EDIT 2'd1

`endif

/* src/clock_display_pkg.sv */
`include "clock_display_macros.svh"

package clock_display_pkg;

  typedef enum logic [1:0] {
    MODE_SHOW      = 2'd0,
    MODE_EDIT_SEC  = 2'd1,
    MODE_EDIT_MIN  = 2'd2,
    MODE_EDIT_HOUR = 2'd3
  } mode_e;

  // two bcd digits, tens in the upper nibble
  typedef logic [2*`CD_DIGIT_W-1:0] bcd2_t;

  // bcd increment that rolls over to zero after limit
  function automatic bcd2_t bcd_wrap_inc(bcd2_t value, bcd2_t limit);
    bcd2_t result;
    if (value == limit) begin
      result = '0;
    end else if (value[`CD_DIGIT_W-1:0] == 4'd9) begin
      result = {value[2*`CD_DIGIT_W-1:`CD_DIGIT_W] + 4'd1, 4'd0};  // carry into tens
    end else begin
      result = value + 8'd1;
    end
    return result;
  endfunction

endpackage

/* src/clock_display_top.sv */
`include "clock_display_macros.svh"

module clock_display_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [`CD_WB_ADDR_W-1:0] wb_adr,
  input  logic [`CD_WB_DATA_W-1:0] wb_dat_i,
  output logic [`CD_WB_DATA_W-1:0] wb_dat_o,
  output logic                     wb_ack,
  input  clock_display_pkg::bcd2_t live_hour,
  input  clock_display_pkg::bcd2_t live_min,
  input  clock_display_pkg::bcd2_t live_sec,
  input  logic                     down_btn,  // active low
  output logic [`CD_LED_W-1:0]     led0,
  output logic [`CD_LED_W-1:0]     led1,
  output logic [`CD_LED_W-1:0]     led2,
  output logic [`CD_LED_W-1:0]     led3,
  output logic [`CD_LED_W-1:0]     led4,
  output logic [`CD_LED_W-1:0]     led5,
  output logic [`CD_LED_W-1:0]     led6,
  output logic [`CD_LED_W-1:0]     led7,
  output logic                     set_time,
  output clock_display_pkg::bcd2_t set_hour,
  output clock_display_pkg::bcd2_t set_min,
  output clock_display_pkg::bcd2_t set_sec
);

  clock_display_pkg::mode_e mode;
  clock_display_pkg::bcd2_t edit_hour;
  clock_display_pkg::bcd2_t edit_min;
  clock_display_pkg::bcd2_t edit_sec;

  wb_mode_regs wb_mode_regs_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack    (wb_ack),
    .mode      (mode),
    .edit_hour (edit_hour),
    .edit_min  (edit_min),
    .edit_sec  (edit_sec)
  );

  time_editor time_editor_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .mode      (mode),
    .down_btn  (down_btn),
    .live_hour (live_hour),
    .live_min  (live_min),
    .live_sec  (live_sec),
    .edit_hour (edit_hour),
    .edit_min  (edit_min),
    .edit_sec  (edit_sec),
    .set_time  (set_time),
    .set_hour  (set_hour),
    .set_min   (set_min),
    .set_sec   (set_sec)
  );

  digit_composer digit_composer_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .mode      (mode),
    .live_hour (live_hour),
    .live_min  (live_min),
    .live_sec  (live_sec),
    .edit_hour (edit_hour),
    .edit_min  (edit_min),
    .edit_sec  (edit_sec),
    .led0      (led0),
    .led1      (led1),
    .led2      (led2),
    .led3      (led3),
    .led4      (led4),
    .led5      (led5),
    .led6      (led6),
    .led7      (led7)
  );

endmodule

/* src/digit_composer.sv */
`include "clock_display_macros.svh"

module digit_composer (
  input  logic                     clk,
  input  logic                     rst_n,
  input  clock_display_pkg::mode_e mode,
  input  clock_display_pkg::bcd2_t live_hour,
  input  clock_display_pkg::bcd2_t live_min,
  input  clock_display_pkg::bcd2_t live_sec,
  input  clock_display_pkg::bcd2_t edit_hour,
  input  clock_display_pkg::bcd2_t edit_min,
  input  clock_display_pkg::bcd2_t edit_sec,
  output logic [`CD_LED_W-1:0]     led0,
  output logic [`CD_LED_W-1:0]     led1,
  output logic [`CD_LED_W-1:0]     led2,
  output logic [`CD_LED_W-1:0]     led3,
  output logic [`CD_LED_W-1:0]     led4,
  output logic [`CD_LED_W-1:0]     led5,
  output logic [`CD_LED_W-1:0]     led6,
  output logic [`CD_LED_W-1:0]     led7
);

  clock_display_pkg::bcd2_t                       hour_src;
  clock_display_pkg::bcd2_t                       min_src;
  clock_display_pkg::bcd2_t                       sec_src;
  logic [`CD_DIGITS-1:0][`CD_DIGIT_W-1:0]         digit_d;
  logic [`CD_DIGITS-1:0][`CD_DIGIT_W-1:0]         digit_q;
  logic [`CD_DIGITS-1:0]                          blink_d;
  logic [`CD_DIGITS-1:0]                          blink_q;

  always_comb begin
    if (mode == clock_display_pkg::MODE_SHOW) begin
      hour_src = live_hour;
      min_src  = live_min;
      sec_src  = live_sec;
    end else begin
      hour_src = edit_hour;
      min_src  = edit_min;
      sec_src  = edit_sec;
    end
  end

  // hh-mm-ss from position 7 down
  assign digit_d = {hour_src, `CD_SEP_CODE, min_src, `CD_SEP_CODE, sec_src};

  always_comb begin
    case (mode)
      clock_display_pkg::MODE_EDIT_SEC:  blink_d = 8'b0000_0011;
      clock_display_pkg::MODE_EDIT_MIN:  blink_d = 8'b0001_1000;
      clock_display_pkg::MODE_EDIT_HOUR: blink_d = 8'b1100_0000;
      default:                           blink_d = '0;
    endcase
  end

  // digit stage
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      digit_q <= '0;
      blink_q <= '0;
    end else begin
      digit_q <= digit_d;
      blink_q <= blink_d;
    end
  end

  // output stage, word is {blink, dot, digit}
  // time modes only, so every dot is lit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      led0 <= '0;
      led1 <= '0;
      led2 <= '0;
      led3 <= '0;
      led4 <= '0;
      led5 <= '0;
      led6 <= '0;
      led7 <= '0;
    end else begin
      led0 <= {blink_q[0], 1'b1, digit_q[0]};
      led1 <= {blink_q[1], 1'b1, digit_q[1]};
      led2 <= {blink_q[2], 1'b1, digit_q[2]};
      led3 <= {blink_q[3], 1'b1, digit_q[3]};
      led4 <= {blink_q[4], 1'b1, digit_q[4]};
      led5 <= {blink_q[5], 1'b1, digit_q[5]};
      led6 <= {blink_q[6], 1'b1, digit_q[6]};
      led7 <= {blink_q[7], 1'b1, digit_q[7]};
    end
  end

endmodule

/* src/time_editor.sv */
`include "clock_display_macros.svh"

module time_editor (
  input  logic                     clk,
  input  logic                     rst_n,
  input  clock_display_pkg::mode_e mode,
  input  logic                     down_btn,  // active low
  input  clock_display_pkg::bcd2_t live_hour,
  input  clock_display_pkg::bcd2_t live_min,
  input  clock_display_pkg::bcd2_t live_sec,
  output clock_display_pkg::bcd2_t edit_hour,
  output clock_display_pkg::bcd2_t edit_min,
  output clock_display_pkg::bcd2_t edit_sec,
  output logic                     set_time,
  output clock_display_pkg::bcd2_t set_hour,
  output clock_display_pkg::bcd2_t set_min,
  output clock_display_pkg::bcd2_t set_sec
);

  localparam clock_display_pkg::bcd2_t SEC_LIMIT  = 8'h59;
  localparam clock_display_pkg::bcd2_t MIN_LIMIT  = 8'h59;
  localparam clock_display_pkg::bcd2_t HOUR_LIMIT = 8'h23;

  logic [1:0]               btn_q;
  logic                     press;
  clock_display_pkg::mode_e mode_q;
  logic                     commit_det;
  logic                     commit_q;

  // button sampling, idle level is high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      btn_q <= 2'b11;
    end else begin
      btn_q <= {btn_q[0], down_btn};
    end
  end

  assign press = (btn_q == 2'b10);  // high to low

  // edit fields follow the live time outside the edit modes
  always_ff @(posedge clk) begin
    if (mode == clock_display_pkg::MODE_SHOW) begin
      edit_hour <= live_hour;
      edit_min  <= live_min;
      edit_sec  <= live_sec;
    end else if (press) begin
      case (mode)
        clock_display_pkg::MODE_EDIT_SEC: begin
          edit_sec <= clock_display_pkg::bcd_wrap_inc(edit_sec, SEC_LIMIT);
        end
        clock_display_pkg::MODE_EDIT_MIN: begin
          edit_min <= clock_display_pkg::bcd_wrap_inc(edit_min, MIN_LIMIT);
        end
        clock_display_pkg::MODE_EDIT_HOUR: begin
          edit_hour <= clock_display_pkg::bcd_wrap_inc(edit_hour, HOUR_LIMIT);
        end
        default: begin
          edit_sec <= edit_sec;
        end
      endcase
    end
  end

  // leaving an edit mode for show mode
  assign commit_det = (mode == clock_display_pkg::MODE_SHOW) &&
                      (mode_q != clock_display_pkg::MODE_SHOW);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mode_q   <= clock_display_pkg::MODE_SHOW;
      commit_q <= 1'b0;
      set_time <= 1'b0;
    end else begin
      mode_q   <= mode;
      commit_q <= commit_det;
      set_time <= commit_q;  // strobe two edges after the mode write
    end
  end

  // edit regs still hold the edited time on this edge
  always_ff @(posedge clk) begin
    if (commit_det) begin
      set_hour <= edit_hour;
      set_min  <= edit_min;
      set_sec  <= edit_sec;
    end
  end

endmodule

/* src/wb_mode_regs.sv */
`include "clock_display_macros.svh"

module wb_mode_regs (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         wb_cyc,
  input  logic                         wb_stb,
  input  logic                         wb_we,
  input  logic [`CD_WB_ADDR_W-1:0]     wb_adr,
  input  logic [`CD_WB_DATA_W-1:0]     wb_dat_i,
  output logic [`CD_WB_DATA_W-1:0]     wb_dat_o,
  output logic                         wb_ack,
  output clock_display_pkg::mode_e     mode,
  input  clock_display_pkg::bcd2_t     edit_hour,
  input  clock_display_pkg::bcd2_t     edit_min,
  input  clock_display_pkg::bcd2_t     edit_sec
);

  logic                     access;
  logic [`CD_WB_DATA_W-1:0] rd_data;

  // new request, not yet acknowledged
  assign access = wb_cyc & wb_stb & ~wb_ack;

  always_comb begin
    rd_data = '0;  // unmapped reads return zero
    case (wb_adr)
      `CD_REG_MODE: begin
        rd_data = {{(`CD_WB_DATA_W-2){1'b0}}, mode};
      end
      `CD_REG_EDIT: begin
        rd_data = {{(`CD_WB_DATA_W-24){1'b0}}, edit_hour, edit_min, edit_sec};
      end
      default: begin
        rd_data = '0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
      mode   <= clock_display_pkg::MODE_SHOW;
    end else begin
      wb_ack <= access;  // single cycle ack
      if (access && wb_we && (wb_adr == `CD_REG_MODE)) begin
        mode <= clock_display_pkg::mode_e'(wb_dat_i[1:0]);
      end
    end
  end

  // read data sampled with the ack
  always_ff @(posedge clk) begin
    if (access && !wb_we) begin
      wb_dat_o <= rd_data;
    end else if (access) begin
      wb_dat_o <= '0;
    end
  end

endmodule

/* tb/clock_display_tb_util.svh */
// bus, button and polling helpers, included into the testbench module

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
  if (actual !== expected) begin
    fail_now($sformatf("[ERROR] %0t ns: %s = 0x%0h, expected 0x%0h",
                       $time, name, actual, expected));
  end
endtask

// one classic cycle, returns one cycle after the ack was seen
task automatic wb_access(input logic we, input logic [`CD_WB_ADDR_W-1:0] adr,
                         input logic [`CD_WB_DATA_W-1:0] wdata,
                         output logic [`CD_WB_DATA_W-1:0] rdata);
  int cycles;
  cycles = 0;
  wb_cyc   = 1'b1;
  wb_stb   = 1'b1;
  wb_we    = we;
  wb_adr   = adr;
  wb_dat_i = wdata;
  while (wb_ack !== 1'b1) begin
    if (cycles == WB_TIMEOUT) begin
      fail_now($sformatf("no wb_ack within %0d cycles at address %0d", WB_TIMEOUT, adr));
    end
    @(negedge clk);
    cycles++;
  end
  check_value("wb_ack latency", cycles, 1);
  rdata  = wb_dat_o;
  wb_cyc = 1'b0;
  wb_stb = 1'b0;
  wb_we  = 1'b0;
  @(negedge clk);
  check_value("wb_ack", wb_ack, 1'b0);  // one cycle only
endtask

task automatic wb_write(input logic [`CD_WB_ADDR_W-1:0] adr,
                        input logic [`CD_WB_DATA_W-1:0] data);
  logic [`CD_WB_DATA_W-1:0] unused;
  wb_access(1'b1, adr, data, unused);
endtask

task automatic wb_read(input logic [`CD_WB_ADDR_W-1:0] adr,
                       output logic [`CD_WB_DATA_W-1:0] data);
  wb_access(1'b0, adr, '0, data);
endtask

// pin is active low, held long enough for the two-stage sampler
task automatic press_button(input int count);
  repeat (count) begin
    down_btn = 1'b0;
    repeat (3) @(negedge clk);
    down_btn = 1'b1;
    repeat (3) @(negedge clk);
  end
endtask

task automatic wait_leds(input string what);
  int  cycles;
  int  p;
  bit  matched;
  cycles  = 0;
  matched = 1'b0;
  while (!matched) begin
    matched = 1'b1;
    for (p = 0; p < `CD_DIGITS; p++) begin
      if (led[p] !== exp_led[p]) matched = 1'b0;
    end
    if (!matched) begin
      if (cycles == LED_TIMEOUT) begin
        for (p = 0; p < `CD_DIGITS; p++) begin
          check_value($sformatf("led%0d", p), led[p], exp_led[p]);
        end
        fail_now($sformatf("LEDs never showed the %s", what));
      end
      @(negedge clk);
      cycles++;
    end
  end
endtask

/* tb/clock_display_tb.sv */
`include "clock_display_macros.svh"

module clock_display_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WB_TIMEOUT  = 16;
  localparam int LED_TIMEOUT = 24;

  typedef struct packed {
    clock_display_pkg::bcd2_t hour;
    clock_display_pkg::bcd2_t min;
    clock_display_pkg::bcd2_t sec;
    clock_display_pkg::mode_e mode;
    logic [7:0]               presses;
    clock_display_pkg::bcd2_t exp_hour;
    clock_display_pkg::bcd2_t exp_min;
    clock_display_pkg::bcd2_t exp_sec;
  } edit_row_t;

  logic                     clk;
  logic                     rst_n;
  logic                     wb_cyc;
  logic                     wb_stb;
  logic                     wb_we;
  logic [`CD_WB_ADDR_W-1:0] wb_adr;
  logic [`CD_WB_DATA_W-1:0] wb_dat_i;
  logic [`CD_WB_DATA_W-1:0] wb_dat_o;
  logic                     wb_ack;
  clock_display_pkg::bcd2_t live_hour;
  clock_display_pkg::bcd2_t live_min;
  clock_display_pkg::bcd2_t live_sec;
  logic                     down_btn;
  logic [`CD_LED_W-1:0]     led [`CD_DIGITS];
  logic [`CD_LED_W-1:0]     exp_led [`CD_DIGITS];
  logic                     set_time;
  clock_display_pkg::bcd2_t set_hour;
  clock_display_pkg::bcd2_t set_min;
  clock_display_pkg::bcd2_t set_sec;
  edit_row_t                rows [$];

  clock_display_top clock_display_top_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack    (wb_ack),
    .live_hour (live_hour),
    .live_min  (live_min),
    .live_sec  (live_sec),
    .down_btn  (down_btn),
    .led0      (led[0]),
    .led1      (led[1]),
    .led2      (led[2]),
    .led3      (led[3]),
    .led4      (led[4]),
    .led5      (led[5]),
    .led6      (led[6]),
    .led7      (led[7]),
    .set_time  (set_time),
    .set_hour  (set_hour),
    .set_min   (set_min),
    .set_sec   (set_sec)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  `include "clock_display_tb_util.svh"

  task automatic fail_now(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "stopped at first error");
  endtask

  // count up through the decimal value, back to zero past top
  function automatic clock_display_pkg::bcd2_t bcd_step(clock_display_pkg::bcd2_t value,
                                                         int top);
    int         n;
    logic [3:0] tens;
    logic [3:0] units;
    n = value[7:4] * 10 + value[3:0];
    n = (n >= top) ? 0 : n + 1;
    tens  = 4'(n / 10);
    units = 4'(n % 10);
    return {tens, units};
  endfunction

  task automatic add_row(input clock_display_pkg::bcd2_t h, input clock_display_pkg::bcd2_t m,
                         input clock_display_pkg::bcd2_t s,
                         input clock_display_pkg::mode_e mode, input int presses);
    edit_row_t row;
    row.hour     = h;
    row.min      = m;
    row.sec      = s;
    row.mode     = mode;
    row.presses  = 8'(presses);
    row.exp_hour = h;
    row.exp_min  = m;
    row.exp_sec  = s;
    repeat (presses) begin
      case (mode)
        clock_display_pkg::MODE_EDIT_SEC:  row.exp_sec  = bcd_step(row.exp_sec, 59);
        clock_display_pkg::MODE_EDIT_MIN:  row.exp_min  = bcd_step(row.exp_min, 59);
        clock_display_pkg::MODE_EDIT_HOUR: row.exp_hour = bcd_step(row.exp_hour, 23);
        default:                           row.exp_sec  = row.exp_sec;
      endcase
    end
    rows.push_back(row);
  endtask

  // hh sep mm sep ss from position 7 down, dot always lit
  task automatic fill_expected(input clock_display_pkg::bcd2_t h,
                               input clock_display_pkg::bcd2_t m,
                               input clock_display_pkg::bcd2_t s,
                               input clock_display_pkg::mode_e mode);
    logic [`CD_DIGITS-1:0]  blink;
    logic [`CD_DIGIT_W-1:0] digit [`CD_DIGITS];
    int                     p;
    blink = '0;
    if (mode == clock_display_pkg::MODE_EDIT_SEC) blink[1:0] = 2'b11;
    if (mode == clock_display_pkg::MODE_EDIT_MIN) blink[4:3] = 2'b11;
    if (mode == clock_display_pkg::MODE_EDIT_HOUR) blink[7:6] = 2'b11;
    digit[7] = h[7:4];
    digit[6] = h[3:0];
    digit[5] = 4'd10;
    digit[4] = m[7:4];
    digit[3] = m[3:0];
    digit[2] = 4'd10;
    digit[1] = s[7:4];
    digit[0] = s[3:0];
    for (p = 0; p < `CD_DIGITS; p++) begin
      exp_led[p] = {blink[p], 1'b1, digit[p]};
    end
  endtask

  // entered one cycle after the ack edge of the show write
  task automatic check_commit(input edit_row_t row);
    check_value("set_time", set_time, 1'b0);
    @(negedge clk);
    check_value("set_time", set_time, 1'b1);
    check_value("set_hour", set_hour, row.exp_hour);
    check_value("set_min", set_min, row.exp_min);
    check_value("set_sec", set_sec, row.exp_sec);
    repeat (4) begin
      @(negedge clk);
      check_value("set_time", set_time, 1'b0);
    end
    check_value("set_hour held", set_hour, row.exp_hour);
  endtask

  task automatic run_row(input edit_row_t row);
    logic [`CD_WB_DATA_W-1:0] rdata;
    live_hour = row.hour;
    live_min  = row.min;
    live_sec  = row.sec;
    fill_expected(row.hour, row.min, row.sec, clock_display_pkg::MODE_SHOW);
    wait_leds("live time in show mode");
    wb_write(`CD_REG_MODE, {30'd0, row.mode});
    live_hour = 8'h11;  // edit view must ignore live time
    live_min  = 8'h22;
    live_sec  = 8'h33;
    press_button(row.presses);
    wb_read(`CD_REG_EDIT, rdata);
    check_value("edit readback", rdata, {8'h00, row.exp_hour, row.exp_min, row.exp_sec});
    fill_expected(row.exp_hour, row.exp_min, row.exp_sec, row.mode);
    wait_leds("edited time with blink mask");
    wb_write(`CD_REG_MODE, {30'd0, clock_display_pkg::MODE_SHOW});
    check_commit(row);
  endtask

  initial begin
    logic [`CD_WB_DATA_W-1:0] rdata;
    int                       p;
    rst_n     = 1'b0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_i  = '0;
    live_hour = 8'h00;
    live_min  = 8'h00;
    live_sec  = 8'h00;
    down_btn  = 1'b1;
    add_row(8'h12, 8'h34, 8'h56, clock_display_pkg::MODE_EDIT_SEC, 2);
    add_row(8'h12, 8'h34, 8'h58, clock_display_pkg::MODE_EDIT_SEC, 3);
    add_row(8'h07, 8'h59, 8'h10, clock_display_pkg::MODE_EDIT_MIN, 1);
    add_row(8'h07, 8'h08, 8'h10, clock_display_pkg::MODE_EDIT_MIN, 4);
    add_row(8'h22, 8'h45, 8'h30, clock_display_pkg::MODE_EDIT_HOUR, 2);
    add_row(8'h09, 8'h15, 8'h00, clock_display_pkg::MODE_EDIT_HOUR, 1);
    add_row(8'h23, 8'h59, 8'h59, clock_display_pkg::MODE_EDIT_SEC, 0);
    repeat (15) @(negedge clk);
    for (p = 0; p < `CD_DIGITS; p++) begin
      check_value($sformatf("led%0d in reset", p), led[p], '0);
    end
    check_value("set_time in reset", set_time, 1'b0);
    check_value("wb_ack in reset", wb_ack, 1'b0);
    @(negedge clk);
    rst_n = 1'b1;
    for (p = 0; p < rows.size(); p++) begin
      run_row(rows[p]);
    end
    // mode register and unmapped addresses
    wb_write(`CD_REG_MODE, {30'd0, clock_display_pkg::MODE_EDIT_MIN});
    wb_read(`CD_REG_MODE, rdata);
    check_value("mode readback", rdata, 32'd2);
    wb_write(2'd3, 32'h0000_0003);
    wb_read(`CD_REG_MODE, rdata);
    check_value("mode after unmapped write", rdata, 32'd2);
    wb_read(2'd2, rdata);
    check_value("unmapped read 2", rdata, 32'd0);
    wb_read(2'd3, rdata);
    check_value("unmapped read 3", rdata, 32'd0);
    wb_write(`CD_REG_MODE, {30'd0, clock_display_pkg::MODE_SHOW});
    wb_read(`CD_REG_MODE, rdata);
    check_value("mode back to show", rdata, 32'd0);
    $display(">>> PASS");
    $finish;
  end

endmodule
